//--- common/cpuPkg.sv
package cpuPkg;

        localparam int dataW = 8;               // Data path width
        localparam int addrW = 16;              // Address bus width

        typedef logic [dataW-1:0] byteT;
        typedef logic [addrW-1:0] addrT;
        typedef logic [2:0]       stepT;        // Execute step index

        // ------------------------------------------------------------------
        // Supported opcodes with their 6502 encodings
        // ------------------------------------------------------------------
        typedef enum logic [7:0] {
                opOraImm = 8'h09,
                opAsl    = 8'h0A,
                opClc    = 8'h18,
                opAndImm = 8'h29,
                opRol    = 8'h2A,
                opSec    = 8'h38,
                opEorImm = 8'h49,
                opLsr    = 8'h4A,
                opAdcImm = 8'h69,
                opRor    = 8'h6A,
                opTxa    = 8'h8A,
                opTya    = 8'h98,
                opLdyImm = 8'hA0,
                opLdxImm = 8'hA2,
                opTay    = 8'hA8,
                opLdaImm = 8'hA9,
                opTax    = 8'hAA,
                opClv    = 8'hB8,
                opCmpImm = 8'hC9,
                opSbcImm = 8'hE9,
                opNop    = 8'hEA
        } opcodeE;

        typedef enum logic [3:0] {
                aluAdd,         // A + B + C
                aluSub,         // A - B - borrow
                aluAnd,
                aluOr,
                aluXor,
                aluAsl,
                aluLsr,
                aluRol,
                aluRor,
                aluPass         // B straight through
        } aluOpE;

        // First ALU operand source
        typedef enum logic [1:0] {
                srcA,
                srcX,
                srcY
        } srcE;

        typedef enum logic [1:0] {
                flagNone,
                flagClearC,
                flagSetC,
                flagClearV
        } flagOpE;

        typedef enum logic [1:0] {
                stFetch,
                stDecode,
                stExecute
        } seqStateE;

endpackage

//--- control/instrSequencer.sv
`timescale 1ns/1ps

module instrSequencer (
        input  logic            clk,
        input  logic            rstN,
        input  cpuPkg::byteT    memData,
        input  logic            lastStep,
        input  logic            operandRead,
        input  logic            stepIncPc,
        output cpuPkg::opcodeE  opcode,
        output cpuPkg::stepT    step,
        output logic            memRead,
        output logic            incPc,
        output logic            instrDone
);

        cpuPkg::seqStateE state;
        logic             running;      // Set once reset has been released

        // ------------------------------------------------------------------
        // Instruction cycle FSM
        // ------------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        state   <= cpuPkg::stFetch;
                        opcode  <= cpuPkg::opNop;       // ROM idle until first decode
                        step    <= '0;
                        running <= 1'b0;
                end
                else begin
                        running <= 1'b1;
                        case (state)
                        cpuPkg::stFetch:
                                if (running)
                                        state <= cpuPkg::stDecode;      // Opcode arrives next
                        cpuPkg::stDecode: begin
                                opcode <= cpuPkg::opcodeE'(memData);    // Unknown codes kept as is
                                state  <= cpuPkg::stExecute;
                        end
                        cpuPkg::stExecute:
                                if (lastStep) begin
                                        opcode <= cpuPkg::opNop;    // ROM idle until next opcode
                                        step   <= '0;
                                        state  <= cpuPkg::stFetch;
                                end
                                else begin
                                        step <= step + 1'b1;    // Next microcode step
                                end
                        default: state <= cpuPkg::stFetch;
                        endcase
                end
        end

        // Strobes decoded from state and current microcode step
        assign memRead   = (state == cpuPkg::stFetch && running) ||
                           (state == cpuPkg::stExecute && operandRead);
        assign incPc     = (state == cpuPkg::stDecode) ||
                           (state == cpuPkg::stExecute && stepIncPc);
        assign instrDone = (state == cpuPkg::stExecute) && lastStep;     // One cycle pulse

endmodule

//--- control/microcodeRom.sv
`timescale 1ns/1ps

module microcodeRom (
        input  cpuPkg::opcodeE  opcode,
        input  cpuPkg::stepT    step,
        output logic            operandRead,
        output logic            lastStep,
        output logic            loadA,
        output logic            loadX,
        output logic            loadY,
        output cpuPkg::aluOpE   aluOp,
        output cpuPkg::srcE     aluSrc,
        output logic            useMem,
        output logic            setNz,
        output logic            setC,
        output logic            setV,
        output cpuPkg::flagOpE  flagOp,
        output logic            stepIncPc
);

        logic immOp;            // Opcode carries an immediate byte
        logic execNow;          // This step performs the operation

        always_comb begin
                case (opcode)
                cpuPkg::opLdaImm, cpuPkg::opLdxImm, cpuPkg::opLdyImm,
                cpuPkg::opAdcImm, cpuPkg::opSbcImm, cpuPkg::opAndImm,
                cpuPkg::opOraImm, cpuPkg::opEorImm, cpuPkg::opCmpImm:
                        immOp = 1'b1;
                default:
                        immOp = 1'b0;
                endcase
        end

        // Immediate ops fetch in step 0 and execute in step 1
        assign execNow     = !immOp || (step == cpuPkg::stepT'(1));
        assign operandRead = immOp && (step == '0);
        assign lastStep    = !operandRead;      // Stray steps end as NOP
        assign stepIncPc   = immOp && execNow;  // Skip past the operand
        assign useMem      = immOp && execNow;

        // ------------------------------------------------------------------
        // Control table per opcode, active on the executing step
        // ------------------------------------------------------------------
        always_comb begin
                loadA  = 1'b0;
                loadX  = 1'b0;
                loadY  = 1'b0;
                aluOp  = cpuPkg::aluPass;
                aluSrc = cpuPkg::srcA;
                setNz  = 1'b0;
                setC   = 1'b0;
                setV   = 1'b0;
                flagOp = cpuPkg::flagNone;
                if (execNow) begin
                        case (opcode)
                        // Loads
                        cpuPkg::opLdaImm: begin loadA = 1'b1; setNz = 1'b1; end
                        cpuPkg::opLdxImm: begin loadX = 1'b1; setNz = 1'b1; end
                        cpuPkg::opLdyImm: begin loadY = 1'b1; setNz = 1'b1; end

                        // Arithmetic and logic
                        cpuPkg::opAdcImm, cpuPkg::opSbcImm: begin
                                aluOp = (opcode == cpuPkg::opAdcImm) ? cpuPkg::aluAdd
                                                                     : cpuPkg::aluSub;
                                loadA = 1'b1;
                                setNz = 1'b1;
                                setC  = 1'b1;
                                setV  = 1'b1;
                        end
                        cpuPkg::opAndImm: begin aluOp = cpuPkg::aluAnd; loadA = 1'b1; setNz = 1'b1; end
                        cpuPkg::opOraImm: begin aluOp = cpuPkg::aluOr;  loadA = 1'b1; setNz = 1'b1; end
                        cpuPkg::opEorImm: begin aluOp = cpuPkg::aluXor; loadA = 1'b1; setNz = 1'b1; end
                        cpuPkg::opCmpImm: begin
                                aluOp = cpuPkg::aluSub;         // Flags only, A untouched
                                setNz = 1'b1;
                                setC  = 1'b1;
                        end

                        // Shifts and rotates on A
                        cpuPkg::opAsl: begin aluOp = cpuPkg::aluAsl; loadA = 1'b1; setNz = 1'b1; setC = 1'b1; end
                        cpuPkg::opLsr: begin aluOp = cpuPkg::aluLsr; loadA = 1'b1; setNz = 1'b1; setC = 1'b1; end
                        cpuPkg::opRol: begin aluOp = cpuPkg::aluRol; loadA = 1'b1; setNz = 1'b1; setC = 1'b1; end
                        cpuPkg::opRor: begin aluOp = cpuPkg::aluRor; loadA = 1'b1; setNz = 1'b1; setC = 1'b1; end

                        // Transfers through PASS
                        cpuPkg::opTax: begin loadX = 1'b1; setNz = 1'b1; end
                        cpuPkg::opTay: begin loadY = 1'b1; setNz = 1'b1; end
                        cpuPkg::opTxa: begin aluSrc = cpuPkg::srcX; loadA = 1'b1; setNz = 1'b1; end
                        cpuPkg::opTya: begin aluSrc = cpuPkg::srcY; loadA = 1'b1; setNz = 1'b1; end

                        // Flags
                        cpuPkg::opClc: flagOp = cpuPkg::flagClearC;
                        cpuPkg::opSec: flagOp = cpuPkg::flagSetC;
                        cpuPkg::opClv: flagOp = cpuPkg::flagClearV;

                        cpuPkg::opNop: ;                        // Nothing to do
                        default: ;                              // Unknown opcode acts as NOP
                        endcase
                end
        end

endmodule

//--- hdl/programCounter.sv
`timescale 1ns/1ps

module programCounter #(
        parameter cpuPkg::addrT resetPc = 16'h0000
) (
        input  logic            clk,
        input  logic            rstN,
        input  logic            incPc,
        output cpuPkg::addrT    pc
);

        always_ff @(posedge clk) begin
                if (!rstN)
                        pc <= resetPc;          // Start address
                else if (incPc)
                        pc <= pc + 1'b1;        // Rolls over from FFFF to 0000
        end

endmodule

//--- datapath/alu.sv
`timescale 1ns/1ps

module alu (
        input  cpuPkg::byteT    opA,
        input  cpuPkg::byteT    opB,
        input  logic            carryIn,
        input  cpuPkg::aluOpE   aluOp,
        output cpuPkg::byteT    result,
        output logic            carryOut,
        output logic            overflow
);

        localparam int msb = cpuPkg::dataW - 1;

        logic [cpuPkg::dataW:0] sum;    // Adder with carry bit on top
        logic                   isSub;

        // Subtract is add of the inverted operand, carry in means no borrow
        assign isSub = (aluOp == cpuPkg::aluSub);
        assign sum   = {1'b0, opA} + {1'b0, (isSub ? ~opB : opB)} + carryIn;

        always_comb begin
                result   = opB;
                carryOut = carryIn;     // Held unless the op defines it
                overflow = 1'b0;
                case (aluOp)
                cpuPkg::aluAdd, cpuPkg::aluSub: begin
                        result   = sum[msb:0];
                        carryOut = sum[cpuPkg::dataW];
                        // Signed overflow when like-signed inputs give a flipped sign
                        overflow = (opA[msb] == (opB[msb] ^ isSub)) &&
                                   (sum[msb] != opA[msb]);
                end
                cpuPkg::aluAnd: result = opA & opB;
                cpuPkg::aluOr:  result = opA | opB;
                cpuPkg::aluXor: result = opA ^ opB;
                cpuPkg::aluAsl: begin
                        result   = {opA[msb-1:0], 1'b0};
                        carryOut = opA[msb];
                end
                cpuPkg::aluLsr: begin
                        result   = {1'b0, opA[msb:1]};
                        carryOut = opA[0];
                end
                cpuPkg::aluRol: begin
                        result   = {opA[msb-1:0], carryIn};    // Old carry into bit 0
                        carryOut = opA[msb];
                end
                cpuPkg::aluRor: begin
                        result   = {carryIn, opA[msb:1]};      // Old carry into bit 7
                        carryOut = opA[0];
                end
                default: result = opB;  // PASS
                endcase
        end

endmodule

//--- datapath/registerBank.sv
`timescale 1ns/1ps

module registerBank (
        input  logic            clk,
        input  logic            rstN,
        input  cpuPkg::byteT    memData,
        input  logic            loadA,
        input  logic            loadX,
        input  logic            loadY,
        input  cpuPkg::srcE     aluSrc,
        input  logic            useMem,
        input  logic            setNz,
        input  logic            setC,
        input  logic            setV,
        input  cpuPkg::flagOpE  flagOp,
        input  cpuPkg::byteT    result,
        input  logic            carryOut,
        input  logic            overflow,
        output cpuPkg::byteT    aluA,
        output cpuPkg::byteT    aluB,
        output cpuPkg::byteT    regA,
        output cpuPkg::byteT    regX,
        output cpuPkg::byteT    regY,
        output logic            flagN,
        output logic            flagZ,
        output logic            flagC,
        output logic            flagV
);

        cpuPkg::byteT srcReg;

        // ------------------------------------------------------------------
        // Operand select
        // ------------------------------------------------------------------
        always_comb begin
                case (aluSrc)
                cpuPkg::srcX: srcReg = regX;
                cpuPkg::srcY: srcReg = regY;
                default:      srcReg = regA;
                endcase
        end

        assign aluA = srcReg;
        assign aluB = useMem ? memData : srcReg;        // Immediate byte or register

        // ------------------------------------------------------------------
        // Registers and flags
        // ------------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        regA  <= '0;
                        regX  <= '0;
                        regY  <= '0;
                        flagN <= 1'b0;
                        flagZ <= 1'b0;
                        flagC <= 1'b0;
                        flagV <= 1'b0;
                end
                else begin
                        if (loadA) regA <= result;
                        if (loadX) regX <= result;
                        if (loadY) regY <= result;
                        if (setNz) begin
                                flagN <= result[cpuPkg::dataW-1];
                                flagZ <= (result == '0);
                        end
                        if (setC) flagC <= carryOut;
                        if (setV) flagV <= overflow;
                        case (flagOp)   // Explicit flag instructions
                        cpuPkg::flagClearC: flagC <= 1'b0;
                        cpuPkg::flagSetC:   flagC <= 1'b1;
                        cpuPkg::flagClearV: flagV <= 1'b0;
                        default: ;
                        endcase
                end
        end

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
        parameter cpuPkg::addrT resetPc = 16'h0000
) (
        input  logic            clk,
        input  logic            rstN,
        output logic            memRead,
        input  cpuPkg::byteT    memData,
        output cpuPkg::addrT    pc,
        output cpuPkg::byteT    regA,
        output cpuPkg::byteT    regX,
        output cpuPkg::byteT    regY,
        output logic            flagN,
        output logic            flagZ,
        output logic            flagC,
        output logic            flagV,
        output logic            instrDone
);

        // Sequencer to ROM
        cpuPkg::opcodeE opcode;
        cpuPkg::stepT   step;
        logic           incPc;

        // ROM control word
        logic            operandRead, lastStep, stepIncPc;
        logic            loadA, loadX, loadY, useMem;
        logic            setNz, setC, setV;
        cpuPkg::aluOpE   aluOp;
        cpuPkg::srcE     aluSrc;
        cpuPkg::flagOpE  flagOp;

        // ALU operands and results
        cpuPkg::byteT    aluA, aluB, result;
        logic            carryOut, overflow;
        logic            aluCarryIn;     // Carry into the adder

        // CMP subtracts with carry set and ignores the borrow
        assign aluCarryIn = (aluOp == cpuPkg::aluSub && !loadA) ? 1'b1 : flagC;

        instrSequencer uSeq (
                .clk(clk), .rstN(rstN), .memData(memData),
                .lastStep(lastStep), .operandRead(operandRead), .stepIncPc(stepIncPc),
                .opcode(opcode), .step(step),
                .memRead(memRead), .incPc(incPc), .instrDone(instrDone)
        );

        microcodeRom uRom (
                .opcode(opcode), .step(step),
                .operandRead(operandRead), .lastStep(lastStep),
                .loadA(loadA), .loadX(loadX), .loadY(loadY),
                .aluOp(aluOp), .aluSrc(aluSrc), .useMem(useMem),
                .setNz(setNz), .setC(setC), .setV(setV),
                .flagOp(flagOp), .stepIncPc(stepIncPc)
        );

        programCounter #(.resetPc(resetPc)) uPc (
                .clk(clk), .rstN(rstN), .incPc(incPc), .pc(pc)
        );

        alu uAlu (
                .opA(aluA), .opB(aluB), .carryIn(aluCarryIn), .aluOp(aluOp),
                .result(result), .carryOut(carryOut), .overflow(overflow)
        );

        registerBank uRegs (
                .clk(clk), .rstN(rstN), .memData(memData),
                .loadA(loadA), .loadX(loadX), .loadY(loadY),
                .aluSrc(aluSrc), .useMem(useMem),
                .setNz(setNz), .setC(setC), .setV(setV), .flagOp(flagOp),
                .result(result), .carryOut(carryOut), .overflow(overflow),
                .aluA(aluA), .aluB(aluB),
                .regA(regA), .regX(regX), .regY(regY),
                .flagN(flagN), .flagZ(flagZ), .flagC(flagC), .flagV(flagV)
        );

endmodule

//--- verification/cpuCore_assertions.sv
`timescale 1ns/1ps

module cpuCoreAssertions (
        input  logic            clk,
        input  logic            rstN,
        input  logic            memRead,
        input  logic            instrDone,
        input  cpuPkg::addrT    pc
);

        // ------------------------------------------------------------------
        // Completion and fetch timing
        // ------------------------------------------------------------------
        donePulse: assert property (@(posedge clk) disable iff (!rstN)
                instrDone |=> !instrDone)
                else $error("instrDone stayed high for two cycles");

        fetchFollowsDone: assert property (@(posedge clk) disable iff (!rstN)
                instrDone |=> memRead)          // FETCH right after the last step
                else $error("memRead low on the cycle after instrDone");

        // pc moves by one, and only in DECODE or the last immediate step
        // Both of those cycles come straight after a memRead cycle
        pcStep: assert property (@(posedge clk) disable iff (!rstN)
                (pc != $past(pc)) |-> ($past(memRead, 2) && (pc == $past(pc) + 16'd1)))
                else $error("pc changed outside DECODE or the operand step");

endmodule

bind cpuCore cpuCoreAssertions uAssertions (
        .clk(clk),
        .rstN(rstN),
        .memRead(memRead),
        .instrDone(instrDone),
        .pc(pc)
);

//--- verification/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

        localparam cpuPkg::addrT startPc = 16'h0200;

        // One program row and the state expected once it retires
        typedef struct packed {
                cpuPkg::byteT opcode;
                cpuPkg::byteT operand;
                cpuPkg::byteT expA;
                cpuPkg::byteT expX;
                cpuPkg::byteT expY;
                logic [3:0]   nzcv;     // Expected N Z C V, N in bit 3
                logic [1:0]   len;      // Bytes in the instruction
        } rowT;

        logic           clk;
        logic           rstN;
        logic           memRead;
        cpuPkg::byteT   memData;
        cpuPkg::addrT   pc;
        cpuPkg::byteT   regA, regX, regY;
        logic           flagN, flagZ, flagC, flagV;
        logic           instrDone;

        cpuPkg::byteT   mem [0:65535];  // Full 64K program memory
        rowT            rows [$];
        int             cycleCount = 0;
        int             cycleLimit = 0;
        string          stage = "after reset";

        cpuCore #(.resetPc(startPc)) dut (
                .clk(clk), .rstN(rstN), .memRead(memRead), .memData(memData), .pc(pc),
                .regA(regA), .regX(regX), .regY(regY),
                .flagN(flagN), .flagZ(flagZ), .flagC(flagC), .flagV(flagV),
                .instrDone(instrDone)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;          // 4 ns period
        end

        // ------------------------------------------------------------------
        // Reporting and compare tasks
        // ------------------------------------------------------------------
        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Simulation failed");
                $fatal(1);
        endtask

        task automatic checkByte(input string name, input cpuPkg::byteT got,
                                 input cpuPkg::byteT exp);
                if (got !== exp)
                        abortRun($sformatf("error %s %s: got 0x%h, expected 0x%h",
                                           name, stage, got, exp));
        endtask

        task automatic checkAddr(input string name, input cpuPkg::addrT got,
                                 input cpuPkg::addrT exp);
                if (got !== exp)
                        abortRun($sformatf("error %s %s: got 0x%h, expected 0x%h",
                                           name, stage, got, exp));
        endtask

        task automatic checkFlag(input string name, input logic got, input logic exp);
                if (got !== exp)
                        abortRun($sformatf("error %s %s: got 0x%h, expected 0x%h",
                                           name, stage, got, exp));
        endtask

        task automatic checkState(input rowT row, input cpuPkg::addrT expPc);
                checkAddr("pc", pc, expPc);
                checkByte("regA", regA, row.expA);
                checkByte("regX", regX, row.expX);
                checkByte("regY", regY, row.expY);
                checkFlag("flagN", flagN, row.nzcv[3]);
                checkFlag("flagZ", flagZ, row.nzcv[2]);
                checkFlag("flagC", flagC, row.nzcv[1]);
                checkFlag("flagV", flagV, row.nzcv[0]);
        endtask

        // ------------------------------------------------------------------
        // Program table and memory model
        // ------------------------------------------------------------------
        task automatic addRow(input cpuPkg::byteT op, input cpuPkg::byteT arg,
                              input cpuPkg::byteT a, input cpuPkg::byteT x,
                              input cpuPkg::byteT y, input logic [3:0] nzcv, input int len);
                rowT row;
                row = '{op, arg, a, x, y, nzcv, 2'(len)};
                rows.push_back(row);
        endtask

        task automatic buildTable();
                // opcode            operand A      X      Y      NZCV     len
                addRow(cpuPkg::opLdaImm, 8'h00, 8'h00, 8'h00, 8'h00, 4'b0100, 2);
                addRow(cpuPkg::opLdxImm, 8'h80, 8'h00, 8'h80, 8'h00, 4'b1000, 2);
                addRow(cpuPkg::opLdaImm, 8'h50, 8'h50, 8'h80, 8'h00, 4'b0000, 2);
                addRow(cpuPkg::opAdcImm, 8'h50, 8'hA0, 8'h80, 8'h00, 4'b1001, 2); // Signed ovf
                addRow(cpuPkg::opClv,    8'h00, 8'hA0, 8'h80, 8'h00, 4'b1000, 1);
                addRow(cpuPkg::opSec,    8'h00, 8'hA0, 8'h80, 8'h00, 4'b1010, 1);
                addRow(cpuPkg::opLdaImm, 8'h00, 8'h00, 8'h80, 8'h00, 4'b0110, 2);
                addRow(cpuPkg::opSbcImm, 8'h01, 8'hFF, 8'h80, 8'h00, 4'b1000, 2); // Borrow
                addRow(cpuPkg::opAndImm, 8'h0F, 8'h0F, 8'h80, 8'h00, 4'b0000, 2);
                addRow(cpuPkg::opOraImm, 8'h80, 8'h8F, 8'h80, 8'h00, 4'b1000, 2);
                addRow(cpuPkg::opEorImm, 8'h8F, 8'h00, 8'h80, 8'h00, 4'b0100, 2);
                addRow(cpuPkg::opLdaImm, 8'h42, 8'h42, 8'h80, 8'h00, 4'b0000, 2);
                addRow(cpuPkg::opCmpImm, 8'h42, 8'h42, 8'h80, 8'h00, 4'b0110, 2); // Equal
                addRow(cpuPkg::opCmpImm, 8'h50, 8'h42, 8'h80, 8'h00, 4'b1000, 2); // A below
                addRow(cpuPkg::opAsl,    8'h00, 8'h84, 8'h80, 8'h00, 4'b1000, 1);
                addRow(cpuPkg::opAsl,    8'h00, 8'h08, 8'h80, 8'h00, 4'b0010, 1);
                addRow(cpuPkg::opRor,    8'h00, 8'h84, 8'h80, 8'h00, 4'b1000, 1); // Carry in
                addRow(cpuPkg::opRol,    8'h00, 8'h08, 8'h80, 8'h00, 4'b0010, 1);
                addRow(cpuPkg::opRol,    8'h00, 8'h11, 8'h80, 8'h00, 4'b0000, 1);
                addRow(cpuPkg::opLsr,    8'h00, 8'h08, 8'h80, 8'h00, 4'b0010, 1);
                addRow(cpuPkg::opTax,    8'h00, 8'h08, 8'h08, 8'h00, 4'b0010, 1);
                addRow(cpuPkg::opTya,    8'h00, 8'h00, 8'h08, 8'h00, 4'b0110, 1);
                addRow(cpuPkg::opTxa,    8'h00, 8'h08, 8'h08, 8'h00, 4'b0010, 1);
                addRow(cpuPkg::opTay,    8'h00, 8'h08, 8'h08, 8'h08, 4'b0010, 1);
                addRow(cpuPkg::opClc,    8'h00, 8'h08, 8'h08, 8'h08, 4'b0000, 1);
                addRow(cpuPkg::opNop,    8'h00, 8'h08, 8'h08, 8'h08, 4'b0000, 1);
                addRow(8'h02,            8'h00, 8'h08, 8'h08, 8'h08, 4'b0000, 1); // Unknown
        endtask

        task automatic layProgram();
                cpuPkg::addrT addr;
                addr = startPc;
                for (int i = 0; i < 65536; i++)
                        mem[i] = cpuPkg::byteT'(i) ^ cpuPkg::byteT'(i >> 8) ^ 8'hA5;
                foreach (rows[r]) begin
                        mem[addr] = rows[r].opcode;
                        if (rows[r].len == 2)
                                mem[addr + 16'd1] = rows[r].operand;   // Immediate byte
                        addr = addr + cpuPkg::addrT'(rows[r].len);
                end
        endtask

        // Read seen mid cycle is answered just after the next edge
        initial begin
                logic         readPending;
                cpuPkg::addrT readAddr;
                forever begin
                        @(negedge clk);
                        readPending = memRead;
                        readAddr    = pc;
                        @(posedge clk);
                        #1;
                        if (readPending)
                                memData = mem[readAddr];
                end
        end

        always @(posedge clk) begin
                cycleCount = cycleCount + 1;
                if (cycleCount > cycleLimit)
                        abortRun($sformatf("Run timed out after %0d cycles", cycleLimit));
        end

        // ------------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------------
        initial begin
                int           lastDone;
                int           spacing;
                cpuPkg::addrT expPc;
                rstN    = 1'b0;
                memData = '0;
                buildTable();
                cycleLimit = 4 * rows.size() + 20;
                layProgram();
                expPc = startPc;

                repeat (4) @(posedge clk);
                #1 rstN = 1'b1;

                @(negedge clk);                 // No edge with rstN high yet
                checkState('0, startPc);
                checkFlag("memRead", memRead, 1'b0);
                checkFlag("instrDone", instrDone, 1'b0);

                stage = "in first cycle after reset";
                @(negedge clk);
                checkFlag("memRead", memRead, 1'b1);    // FETCH starts here
                lastDone = cycleCount - 1;

                for (int i = 0; i < rows.size(); i++) begin
                        do
                                @(negedge clk);
                        while (!instrDone);
                        spacing = cycleCount - lastDone;
                        if (spacing != rows[i].len + 2)
                                abortRun($sformatf("Row %0d took %0d cycles instead of %0d",
                                                   i, spacing, rows[i].len + 2));
                        lastDone = cycleCount;
                        expPc    = expPc + cpuPkg::addrT'(rows[i].len);
                        @(negedge clk);         // New state one cycle after instrDone
                        stage = $sformatf("after row %0d", i);
                        checkState(rows[i], expPc);
                end

                $display("Simulation completed successfully");
                $finish;
        end

endmodule

//--- compile.f
common/cpuPkg.sv
control/instrSequencer.sv
control/microcodeRom.sv
hdl/programCounter.sv
datapath/alu.sv
datapath/registerBank.sv
hdl/cpuCore.sv
verification/cpuCore_assertions.sv
verification/cpuCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
        -f compile.f --top-module cpuCoreTb -Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

grep -q "Simulation completed successfully" sim.log
echo "Run passed"
